// ==== design/conv_pkg.sv ====
package conv_pkg;

    typedef logic signed [15:0] data_t;  // Pixel, weight and bias word
    typedef logic signed [31:0] acc_t;
    typedef logic [7:0]         addr_t;  // The buffer holds 256 words

    typedef struct packed {
        addr_t addr;
        data_t wdata;
    } host_cmd_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic [7:0] filter;
        logic [7:0] row;
        logic [7:0] col;
        data_t      value;
    } out_pix_t;

    localparam addr_t IFM_BASE  = 8'd0;   // Input map in row-major order
    localparam addr_t WGT_BASE  = 8'd64;  // Filter by filter, each one row-major
    localparam addr_t BIAS_BASE = 8'd96;  // One word per filter

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT_GNT,
        ACCUM,
        BIAS,
        EMIT,
        WAIT_ACK,
        DONE
    } seq_state_t;

endpackage

// ==== design/conv_buffer_mem.sv ====
`timescale 1ns/10ps

module conv_buffer_mem
    import conv_pkg::*;
(
    input  logic     clk,
    input  logic     mem_en,
    input  mem_req_t mem_req,
    output data_t    rdata
);

    data_t mem [256];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.we) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rdata <= mem[mem_req.addr];  // Data is seen by the reader one cycle later
            end
        end
    end

    // The address travels from either peer through the arbiter mux
    a_addr_known: assert property (@(posedge clk)
        mem_en |-> !$isunknown(mem_req.addr))
        else $error("buffer access with unknown address");

endmodule

// ==== design/conv_mem_arbiter.sv ====
`timescale 1ns/10ps

module conv_mem_arbiter
    import conv_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     host_mreq_valid,
    input  mem_req_t host_mreq,
    output logic     host_gnt,
    input  logic     seq_mreq_valid,
    input  mem_req_t seq_mreq,
    output logic     seq_gnt,
    output logic     mem_en,
    output mem_req_t mem_req
);

    logic last_seq;  // Set when the sequencer held the last grant

    always_comb begin
        host_gnt = 1'b0;
        seq_gnt  = 1'b0;
        if (host_mreq_valid && seq_mreq_valid) begin
            host_gnt = last_seq;   // The peer granted last loses
            seq_gnt  = !last_seq;
        end else begin
            host_gnt = host_mreq_valid;
            seq_gnt  = seq_mreq_valid;
        end
    end

    assign mem_en  = host_gnt || seq_gnt;
    assign mem_req = seq_gnt ? seq_mreq : host_mreq;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_seq <= 1'b0;
        end else if (mem_en) begin
            last_seq <= seq_gnt;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
        !(host_gnt && seq_gnt))
        else $error("both peers granted in one cycle");

    // Both peers hold their request, so a loser always wins the next cycle
    a_no_starve: assert property (@(posedge clk) disable iff (!arst_n)
        (host_mreq_valid && !host_gnt) || (seq_mreq_valid && !seq_gnt)
        |=> host_gnt != seq_gnt && host_gnt != $past(host_gnt))
        else $error("waiting peer not granted in the following cycle");

endmodule

// ==== design/conv_host_port.sv ====
`timescale 1ns/10ps

module conv_host_port
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      host_req,
    input  host_cmd_t host_cmd,
    output logic      host_ack,
    output logic      mreq_valid,
    output mem_req_t  mreq,
    input  logic      gnt
);

    typedef enum logic [1:0] {
        HP_IDLE,
        HP_WRITE,
        HP_ACK
    } hp_state_t;

    hp_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= HP_IDLE;
        end else begin
            case (state)
                HP_IDLE: begin
                    if (host_req) state <= HP_WRITE;
                end
                HP_WRITE: begin
                    if (gnt) state <= HP_ACK;  // Ack rises the cycle after the grant
                end
                HP_ACK: begin
                    if (!host_req) state <= HP_IDLE;
                end
                default: state <= HP_IDLE;
            endcase
        end
    end

    assign host_ack   = (state == HP_ACK);
    assign mreq_valid = (state == HP_WRITE);
    assign mreq       = '{we: 1'b1, addr: host_cmd.addr, wdata: host_cmd.wdata};

    a_cmd_stable: assert property (@(posedge clk) disable iff (!arst_n)
        host_req ##1 host_req |-> $stable(host_cmd))
        else $error("host_cmd changed while host_req was high");

endmodule

// ==== design/conv_mac_unit.sv ====
`timescale 1ns/10ps

module conv_mac_unit
    import conv_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  clear,
    input  logic  tap_valid,
    input  data_t pixel,
    input  data_t weight,
    input  logic  finish,
    input  data_t bias,
    output data_t result
);

    localparam acc_t SAT_MAX = 32'sd32767;

    acc_t acc;
    acc_t biased;

    assign biased = acc + acc_t'(bias);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (tap_valid) begin
            acc <= acc + acc_t'(pixel) * acc_t'(weight);
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            if (biased < 0) begin
                result <= '0;  // ReLU
            end else if (biased > SAT_MAX) begin
                result <= 16'sh7fff;
            end else begin
                result <= data_t'(biased);
            end
        end
    end

endmodule

// ==== design/conv_sequencer.sv ====
`timescale 1ns/10ps

module conv_sequencer
    import conv_pkg::*;
#(
    parameter int IFM_SIZE    = 8,
    parameter int KERNEL_SIZE = 3,
    parameter int NUM_FILTERS = 2
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     run_req,
    output logic     run_ack,
    output logic     out_req,
    output out_pix_t out_pix,
    input  logic     out_ack,
    output logic     mreq_valid,
    output mem_req_t mreq,
    input  logic     gnt,
    input  data_t    rdata,
    output logic     clear,
    output logic     tap_valid,
    output logic     finish,
    output data_t    mac_pixel,
    output data_t    mac_weight,
    output data_t    mac_bias,
    input  data_t    result
);

    localparam logic [7:0] OUT_LAST = 8'(IFM_SIZE - KERNEL_SIZE);
    localparam logic [7:0] K_LAST   = 8'(KERNEL_SIZE - 1);
    localparam logic [7:0] F_LAST   = 8'(NUM_FILTERS - 1);

    seq_state_t state;
    logic [7:0] filter;
    logic [7:0] row;
    logic [7:0] col;
    logic [7:0] kx;
    logic [7:0] ky;
    logic       taps_done;  // Weight read of the last tap has been granted
    logic       ifm_pend;
    logic       wgt_pend;
    logic       bias_pend;
    data_t      pix_q;
    addr_t      ifm_addr;
    addr_t      wgt_addr;
    addr_t      bias_addr;
    logic       rd_ifm;
    logic       rd_wgt;
    logic       rd_bias;
    logic       last_pix;
    logic       emit_now;

    assign ifm_addr  = addr_t'(IFM_BASE + (row + ky) * IFM_SIZE + col + kx);
    assign wgt_addr  = addr_t'(WGT_BASE + (filter * KERNEL_SIZE + ky) * KERNEL_SIZE + kx);
    assign bias_addr = addr_t'(BIAS_BASE + filter);

    // ACCUM already asks for the next tap or the bias while the weight is summed
    assign rd_ifm  = (state == ISSUE) || (state == ACCUM && !taps_done);
    assign rd_wgt  = (state == WAIT_GNT);
    assign rd_bias = (state == BIAS) || (state == ACCUM && taps_done);

    assign mreq_valid = rd_ifm || rd_wgt || rd_bias;
    assign mreq = '{we: 1'b0,
                    addr: rd_wgt ? wgt_addr : (rd_bias ? bias_addr : ifm_addr),
                    wdata: '0};

    assign last_pix = (filter == F_LAST) && (row == OUT_LAST) && (col == OUT_LAST);
    assign emit_now = (state == EMIT) && !bias_pend && !out_ack;  // Result lags finish by one

    assign clear      = (state == IDLE && run_req) || (state == WAIT_ACK && out_ack);
    assign tap_valid  = wgt_pend;
    assign finish     = bias_pend;
    assign mac_pixel  = pix_q;
    assign mac_weight = rdata;
    assign mac_bias   = rdata;
    assign run_ack    = (state == DONE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ifm_pend  <= 1'b0;
            wgt_pend  <= 1'b0;
            bias_pend <= 1'b0;
        end else begin
            ifm_pend  <= gnt && rd_ifm;
            wgt_pend  <= gnt && rd_wgt;
            bias_pend <= gnt && rd_bias;
        end
    end

    always_ff @(posedge clk) begin
        if (ifm_pend) pix_q <= rdata;  // Held until the matching weight arrives
        if (emit_now) out_pix <= '{filter: filter, row: row, col: col, value: result};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            filter    <= '0;
            row       <= '0;
            col       <= '0;
            kx        <= '0;
            ky        <= '0;
            taps_done <= 1'b0;
            out_req   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (run_req) begin
                        filter <= '0;
                        row    <= '0;
                        col    <= '0;
                        state  <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (gnt) state <= WAIT_GNT;
                end
                WAIT_GNT: begin
                    if (gnt) begin
                        state <= ACCUM;
                        if (kx == K_LAST) begin
                            kx <= '0;
                            if (ky == K_LAST) begin
                                ky        <= '0;
                                taps_done <= 1'b1;
                            end else begin
                                ky <= ky + 8'd1;
                            end
                        end else begin
                            kx <= kx + 8'd1;
                        end
                    end
                end
                ACCUM: begin
                    if (taps_done) begin
                        state <= gnt ? EMIT : BIAS;
                    end else begin
                        state <= gnt ? WAIT_GNT : ISSUE;
                    end
                end
                BIAS: begin
                    if (gnt) state <= EMIT;
                end
                EMIT: begin
                    if (emit_now) begin
                        out_req <= 1'b1;
                        state   <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (out_ack) begin
                        out_req   <= 1'b0;
                        taps_done <= 1'b0;
                        state     <= last_pix ? DONE : ISSUE;
                        if (col == OUT_LAST) begin
                            col <= '0;
                            if (row == OUT_LAST) begin
                                row    <= '0;
                                filter <= filter + 8'd1;
                            end else begin
                                row <= row + 8'd1;
                            end
                        end else begin
                            col <= col + 8'd1;
                        end
                    end
                end
                DONE: begin
                    if (!run_req) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    initial begin
        assert (int'(IFM_BASE) + IFM_SIZE * IFM_SIZE <= int'(WGT_BASE)
                && int'(WGT_BASE) + NUM_FILTERS * KERNEL_SIZE * KERNEL_SIZE <= int'(BIAS_BASE)
                && int'(BIAS_BASE) + NUM_FILTERS <= 256)
            else $fatal(1, "buffer regions overlap for these layer sizes");
    end

    a_pix_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_req ##1 out_req |-> $stable(out_pix))
        else $error("out_pix changed while out_req was high");

endmodule

// ==== design/conv_layer_top.sv ====
`timescale 1ns/10ps

module conv_layer_top
    import conv_pkg::*;
#(
    parameter int IFM_SIZE    = 8,
    parameter int KERNEL_SIZE = 3,
    parameter int NUM_FILTERS = 2
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      host_req,
    input  host_cmd_t host_cmd,
    output logic      host_ack,
    input  logic      run_req,
    output logic      run_ack,
    output logic      out_req,
    output out_pix_t  out_pix,
    input  logic      out_ack
);

    logic     host_mreq_valid;
    logic     host_gnt;
    mem_req_t host_mreq;
    logic     seq_mreq_valid;
    logic     seq_gnt;
    mem_req_t seq_mreq;
    logic     mem_en;
    mem_req_t mem_req;
    data_t    rdata;
    logic     clear;
    logic     tap_valid;
    logic     finish;
    data_t    mac_pixel;
    data_t    mac_weight;
    data_t    mac_bias;
    data_t    result;

    conv_host_port i_host_port (
        .clk        (clk),
        .arst_n     (arst_n),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .mreq_valid (host_mreq_valid),
        .mreq       (host_mreq),
        .gnt        (host_gnt)
    );

    conv_mem_arbiter i_arbiter (
        .clk             (clk),
        .arst_n          (arst_n),
        .host_mreq_valid (host_mreq_valid),
        .host_mreq       (host_mreq),
        .host_gnt        (host_gnt),
        .seq_mreq_valid  (seq_mreq_valid),
        .seq_mreq        (seq_mreq),
        .seq_gnt         (seq_gnt),
        .mem_en          (mem_en),
        .mem_req         (mem_req)
    );

    conv_buffer_mem i_buffer (
        .clk     (clk),
        .mem_en  (mem_en),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

    conv_sequencer #(
        .IFM_SIZE    (IFM_SIZE),
        .KERNEL_SIZE (KERNEL_SIZE),
        .NUM_FILTERS (NUM_FILTERS)
    ) i_sequencer (
        .clk        (clk),
        .arst_n     (arst_n),
        .run_req    (run_req),
        .run_ack    (run_ack),
        .out_req    (out_req),
        .out_pix    (out_pix),
        .out_ack    (out_ack),
        .mreq_valid (seq_mreq_valid),
        .mreq       (seq_mreq),
        .gnt        (seq_gnt),
        .rdata      (rdata),
        .clear      (clear),
        .tap_valid  (tap_valid),
        .finish     (finish),
        .mac_pixel  (mac_pixel),
        .mac_weight (mac_weight),
        .mac_bias   (mac_bias),
        .result     (result)
    );

    conv_mac_unit i_mac (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear),
        .tap_valid (tap_valid),
        .pixel     (mac_pixel),
        .weight    (mac_weight),
        .finish    (finish),
        .bias      (mac_bias),
        .result    (result)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// ==== bench/conv_layer_tb.sv ====
`timescale 1ns/10ps

module conv_layer_tb
    import conv_pkg::*;
();

    localparam int IFM_SIZE    = 8;
    localparam int KERNEL_SIZE = 3;
    localparam int NUM_FILTERS = 2;
    localparam int OUT_SIZE    = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int NUM_PIX     = NUM_FILTERS * OUT_SIZE * OUT_SIZE;
    localparam int TAPS        = KERNEL_SIZE * KERNEL_SIZE;
    localparam int MAX_CYCLES  = 20000;  // Three runs near 2500 cycles and four loads near 1000 in all
    localparam logic [31:0] LFSR_SEED = 32'ha0143f1c;
    localparam logic [31:0] LFSR_POLY = 32'h80200003;
    localparam addr_t SPARE_ADDR = 8'd120;

    logic      clk;
    logic      arst_n;
    logic      host_req;
    host_cmd_t host_cmd;
    logic      host_ack;
    logic      run_req;
    logic      run_ack;
    logic      out_req;
    out_pix_t  out_pix;
    logic      out_ack;

    data_t       ifm_mem [IFM_SIZE * IFM_SIZE];
    data_t       wgt_mem [NUM_FILTERS * TAPS];
    data_t       bias_mem [NUM_FILTERS];
    logic [31:0] lfsr = LFSR_SEED;
    int          pix_count = 0;
    int          cycles = 0;

    tb_clock_gen #(.PERIOD_NS(20)) i_clock (.clk(clk));

    conv_layer_top #(
        .IFM_SIZE    (IFM_SIZE),
        .KERNEL_SIZE (KERNEL_SIZE),
        .NUM_FILTERS (NUM_FILTERS)
    ) i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .host_req (host_req),
        .host_cmd (host_cmd),
        .host_ack (host_ack),
        .run_req  (run_req),
        .run_ack  (run_ack),
        .out_req  (out_req),
        .out_pix  (out_pix),
        .out_ack  (out_ack)
    );

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
        end
        return bits;
    endfunction

    // Valid convolution with bias, then ReLU and the upper clamp
    function automatic data_t model_pixel(input int f, input int r, input int c);
        acc_t sum;
        sum = acc_t'(bias_mem[f]);
        for (int ky = 0; ky < KERNEL_SIZE; ky++) begin
            for (int kx = 0; kx < KERNEL_SIZE; kx++) begin
                sum += acc_t'(ifm_mem[(r + ky) * IFM_SIZE + c + kx])
                       * acc_t'(wgt_mem[f * TAPS + ky * KERNEL_SIZE + kx]);
            end
        end
        if (sum < 0) return '0;
        if (sum > 32767) return 16'sh7fff;
        return data_t'(sum);
    endfunction

    function automatic logic [23:0] expected_pos(input int n);
        int f;
        int r;
        int c;
        f = n / (OUT_SIZE * OUT_SIZE);
        r = (n / OUT_SIZE) % OUT_SIZE;
        c = n % OUT_SIZE;
        return {8'(f), 8'(r), 8'(c)};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic host_write(input addr_t addr, input data_t value);
        int hold;
        host_cmd = '{addr: addr, wdata: value};
        host_req = 1'b1;
        do next_cycle(); while (!host_ack);
        hold = int'(take_bits(2));  // Req often stays high for a while after the ack
        repeat (hold) next_cycle();
        host_req = 1'b0;
        do next_cycle(); while (host_ack);
    endtask

    task automatic load_ifm();
        logic [15:0] bits;
        for (int i = 0; i < IFM_SIZE * IFM_SIZE; i++) begin
            bits = take_bits(4);
            ifm_mem[i] = data_t'({12'h000, bits[3:1], 1'b1});  // Odd and positive, never zero
            host_write(addr_t'(int'(IFM_BASE) + i), ifm_mem[i]);
        end
    endtask

    // Extreme mode drives filter 0 below zero and the other filters far above 32767
    task automatic load_filters(input bit extreme);
        logic [15:0] bits;
        data_t       value;
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int t = 0; t < TAPS; t++) begin
                bits = take_bits(4);
                if (!extreme) begin
                    value = data_t'({{12{bits[3]}}, bits[3:0]});
                end else if (f == 0) begin
                    value = -16'sd1 - data_t'({12'h000, bits[3:0]});
                end else begin
                    value = 16'sh2000 + data_t'({12'h000, bits[3:0]});
                end
                wgt_mem[f * TAPS + t] = value;
                host_write(addr_t'(int'(WGT_BASE) + f * TAPS + t), value);
            end
            bits = take_bits(4);
            bias_mem[f] = data_t'({{12{bits[3]}}, bits[3:0]});
            host_write(addr_t'(int'(BIAS_BASE) + f), bias_mem[f]);
        end
    endtask

    task automatic run_layer(input bit slow_ack);
        int delay;
        int hold;
        pix_count = 0;
        run_req = 1'b1;
        while (!run_ack) begin
            next_cycle();
            if (out_req && !out_ack) begin
                delay = slow_ack ? int'(take_bits(3)) : 0;
                repeat (delay) next_cycle();
                out_ack = 1'b1;
                while (out_req) next_cycle();
                pix_count++;
                hold = slow_ack ? int'(take_bits(5)) : 0;  // Long holds stall the next result
                repeat (hold) next_cycle();
                out_ack = 1'b0;
            end
        end
        hold = 1 + int'(take_bits(2));
        repeat (hold) next_cycle();  // The host sees run_ack for a while before it lets go
        run_req = 1'b0;
        while (run_ack) next_cycle();
    endtask

    task automatic spare_writes(input int count);
        for (int i = 0; i < count; i++) begin
            repeat (7) next_cycle();
            host_write(SPARE_ADDR, data_t'(i));  // Contends with the sequencer reads
        end
    endtask

    a_value: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> out_pix.value == model_pixel(int'(out_pix.filter),
                                                        int'(out_pix.row), int'(out_pix.col)))
        else fail_now($sformatf("mismatch out_pix.value: got %h expected %h", out_pix.value,
                                model_pixel(int'(out_pix.filter), int'(out_pix.row),
                                            int'(out_pix.col))));

    a_order: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> {out_pix.filter, out_pix.row, out_pix.col} == expected_pos(pix_count))
        else fail_now($sformatf("mismatch out_pix.filter/row/col: got %h expected %h",
                                {out_pix.filter, out_pix.row, out_pix.col},
                                expected_pos(pix_count)));

    a_count: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(run_ack) |-> pix_count == NUM_PIX)
        else fail_now($sformatf("mismatch pix_count at run_ack: got %h expected %h",
                                pix_count, NUM_PIX));

    a_host_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(host_ack) |-> $past(host_req))
        else fail_now("host_ack rose without a pending host_req");
    a_host_hold: assert property (@(posedge clk) disable iff (!arst_n)
        host_req && host_ack |=> host_ack)
        else fail_now("host_ack dropped while host_req was still high");
    a_host_drop: assert property (@(posedge clk) disable iff (!arst_n)
        !host_req && host_ack |=> !host_ack)
        else fail_now("host_ack stayed high after host_req dropped");

    a_out_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> !$past(out_ack))
        else fail_now("out_req rose before out_ack of the previous result dropped");
    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && !out_ack |=> out_req)
        else fail_now("out_req dropped before out_ack was given");
    a_out_drop: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && out_ack |=> !out_req)
        else fail_now("out_req stayed high after out_ack");

    a_run_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(run_ack) |-> $past(run_req))
        else fail_now("run_ack rose without a pending run_req");
    a_run_hold: assert property (@(posedge clk) disable iff (!arst_n)
        run_req && run_ack |=> run_ack)
        else fail_now("run_ack dropped while run_req was still high");
    a_run_drop: assert property (@(posedge clk) disable iff (!arst_n)
        !run_req && run_ack |=> !run_ack)
        else fail_now("run_ack stayed high after run_req dropped");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) fail_now("timeout: the test did not finish within the cycle limit");
    end

    initial begin
        arst_n   = 1'b0;
        host_req = 1'b0;
        host_cmd = '0;
        run_req  = 1'b0;
        out_ack  = 1'b0;
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        next_cycle();

        load_ifm();
        load_filters(1'b0);
        run_layer(1'b1);

        load_filters(1'b1);  // ReLU floor on filter 0, saturation on filter 1
        fork
            run_layer(1'b0);
            spare_writes(20);
        join

        load_filters(1'b0);
        fork
            run_layer(1'b1);
            spare_writes(20);
        join

        next_cycle();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== project.f ====
design/conv_pkg.sv
design/conv_buffer_mem.sv
design/conv_mem_arbiter.sv
design/conv_host_port.sv
design/conv_mac_unit.sv
design/conv_sequencer.sv
design/conv_layer_top.sv
bench/tb_clock_gen.sv
bench/conv_layer_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module conv_layer_tb

sim:
	verilator --binary --timing --assert -f project.f --top-module conv_layer_tb -Mdir obj_dir
	./obj_dir/Vconv_layer_tb 2>&1 | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
